// File: hw/mini_pipe_config.svh
`ifndef MINI_PIPE_CONFIG_SVH
`define MINI_PIPE_CONFIG_SVH

// number of architectural registers
`define MP_NREGS 8

// datapath width in bits
`define MP_DATA_W 16

// iterations per mul op
// MP_DATA_W has to split evenly across them
`define MP_MUL_STEPS 4

`endif

// File: hw/mini_pipe_pkg.sv
`include "mini_pipe_config.svh"

package mini_pipe_pkg;

  typedef logic [`MP_DATA_W-1:0] data_t;           // register value
  typedef logic [$clog2(`MP_NREGS)-1:0] reg_idx_t; // register number
  typedef logic [15:0] instr_t;                    // {op, rd, rs1, rs2, pad}
  typedef logic [6:0] imm_t;                       // li immediate

  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_XOR   = 3'd2,
    OP_MUL   = 3'd3,
    OP_LI    = 3'd4,
    OP_SKIPZ = 3'd5
  } opcode_e;

  typedef struct packed {
    logic     valid;
    opcode_e  opcode;
    reg_idx_t rd;
    data_t    op_a;   // rs1 value
    data_t    op_b;   // rs2 value
    imm_t     imm;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    data_t    value;
  } ex_wb_t;

  typedef struct packed {
    reg_idx_t rd;
    data_t    value;
  } result_t;

  // pending write seen by decode
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
  } dest_t;

  typedef struct packed {
    logic fetch;  // input acceptance
    logic id;
    logic ex;
    logic wb;
  } stage_vec_t;

  typedef struct packed {
    stage_vec_t stall;
    stage_vec_t flush;
  } pipe_ctrl_t;

  typedef enum logic {
    MUL_IDLE,
    MUL_RUN
  } mul_state_e;

endpackage

// File: hw/reg_file.sv
`timescale 1ns/10ps
`include "mini_pipe_config.svh"

module reg_file (
  input  logic                    clk,
  input  logic                    rst,
  input  mini_pipe_pkg::reg_idx_t rs1_i,
  input  mini_pipe_pkg::reg_idx_t rs2_i,
  output mini_pipe_pkg::data_t    rd1_o,
  output mini_pipe_pkg::data_t    rd2_o,
  input  logic                    we_i,  // output handshake from wb
  input  mini_pipe_pkg::reg_idx_t wa_i,
  input  mini_pipe_pkg::data_t    wd_i
);
  import mini_pipe_pkg::*;

  data_t regs_q [`MP_NREGS];

  // all registers come up as zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MP_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[wa_i] <= wd_i;
    end
  end

  // async read, no write-through
  // decode stalls on any pending write to a source
  assign rd1_o = regs_q[rs1_i];
  assign rd2_o = regs_q[rs2_i];

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      instr_valid_i,
  input  mini_pipe_pkg::instr_t     instr_i,
  output logic                      instr_ready_o,
  input  mini_pipe_pkg::pipe_ctrl_t ctrl_i,
  output mini_pipe_pkg::reg_idx_t   rs1_o,
  output mini_pipe_pkg::reg_idx_t   rs2_o,
  input  mini_pipe_pkg::data_t      rd1_i,
  input  mini_pipe_pkg::data_t      rd2_i,
  input  mini_pipe_pkg::dest_t      ex_dest_i,  // write pending in ex
  input  mini_pipe_pkg::dest_t      wb_dest_i,  // write pending in wb
  output logic                      raw_hazard_o,
  output logic                      id_valid_o,
  output mini_pipe_pkg::id_ex_t     id_ex_o
);
  import mini_pipe_pkg::*;

  logic     id_valid_q;
  instr_t   id_instr_q;
  opcode_e  opcode;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     use_rs1;
  logic     use_rs2;

  function automatic logic dest_hit(input reg_idx_t src, input dest_t dest);
    return dest.valid && (dest.rd == src);
  endfunction

  assign instr_ready_o = !ctrl_i.stall.fetch;

  // id entry valid bit
  always_ff @(posedge clk) begin
    if (rst || ctrl_i.flush.id) begin
      id_valid_q <= 1'b0;
    end else if (!ctrl_i.stall.id) begin
      id_valid_q <= instr_valid_i && instr_ready_o;  // bubble when nothing taken
    end
  end

  always_ff @(posedge clk) begin
    if (!ctrl_i.stall.id) begin
      id_instr_q <= instr_i;
    end
  end

  // field split
  assign opcode = opcode_e'(id_instr_q[15:13]);
  assign rd     = id_instr_q[12:10];
  assign rs1    = id_instr_q[9:7];
  assign rs2    = id_instr_q[6:4];  // overlaps li immediate

  assign use_rs1 = (opcode != OP_LI);
  assign use_rs2 = opcode inside {OP_ADD, OP_SUB, OP_XOR, OP_MUL};  // skipz reads rs1 only

  assign rs1_o = rs1;
  assign rs2_o = rs2;

  assign raw_hazard_o = id_valid_q &&
      ((use_rs1 && (dest_hit(rs1, ex_dest_i) || dest_hit(rs1, wb_dest_i))) ||
       (use_rs2 && (dest_hit(rs2, ex_dest_i) || dest_hit(rs2, wb_dest_i))));

  assign id_valid_o = id_valid_q;

  always_comb begin
    id_ex_o.valid  = id_valid_q && !ctrl_i.flush.id;  // skipped instr never reaches ex
    id_ex_o.opcode = opcode;
    id_ex_o.rd     = rd;
    id_ex_o.op_a   = rd1_i;
    id_ex_o.op_b   = rd2_i;
    id_ex_o.imm    = id_instr_q[6:0];
  end

  // a taken instruction lands in id on the next edge
  a_accept_to_id: assert property (@(posedge clk) disable iff (rst)
    instr_valid_i && instr_ready_o |=> id_valid_o);

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/10ps
`include "mini_pipe_config.svh"

module execute_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  mini_pipe_pkg::pipe_ctrl_t ctrl_i,
  input  mini_pipe_pkg::id_ex_t     id_ex_i,
  output mini_pipe_pkg::ex_wb_t     ex_wb_o,
  output mini_pipe_pkg::dest_t      ex_dest_o,
  output logic                      mul_busy_o,
  output logic                      skip_req_o
);
  import mini_pipe_pkg::*;

  localparam int step_w = `MP_DATA_W / `MP_MUL_STEPS;  // multiplier bits per step
  localparam int cnt_w  = $clog2(`MP_MUL_STEPS + 1);

  id_ex_t           ex_q;
  mul_state_e       state_q;
  logic [cnt_w-1:0] cnt_q;
  logic [cnt_w-1:0] cnt_cur;
  logic             done_q;       // product ready for this entry
  logic             skip_pend_q;
  data_t            acc_q;
  data_t            mcand_q;
  data_t            mplier_q;
  data_t            acc_cur;
  data_t            mcand_cur;
  data_t            mplier_cur;
  data_t            partial;
  data_t            alu_res;
  logic             writes_rd;
  logic             mul_start;
  logic             mul_last;
  logic             step_en;
  logic             skip_now;

  always_ff @(posedge clk) begin
    if (rst || ctrl_i.flush.ex) begin
      ex_q.valid <= 1'b0;  // bubble
    end else if (!ctrl_i.stall.ex) begin
      ex_q <= id_ex_i;
    end
  end

  assign writes_rd  = ex_q.valid && (ex_q.opcode != OP_SKIPZ);
  assign mul_busy_o = ex_q.valid && (ex_q.opcode == OP_MUL) && !done_q;
  assign mul_start  = mul_busy_o && (state_q == MUL_IDLE);
  assign step_en    = mul_start || (state_q == MUL_RUN);

  // first step works straight off the ex operands
  always_comb begin
    mcand_cur  = mcand_q;
    mplier_cur = mplier_q;
    acc_cur    = acc_q;
    cnt_cur    = cnt_q;
    if (state_q == MUL_IDLE) begin
      mcand_cur  = ex_q.op_a;
      mplier_cur = ex_q.op_b;
      acc_cur    = '0;
      cnt_cur    = '0;
    end
  end

  always_comb begin
    partial = '0;
    for (int b = 0; b < step_w; b++) begin
      if (mplier_cur[b]) partial = partial + (mcand_cur << b);
    end
  end

  assign mul_last = (cnt_cur == cnt_w'(`MP_MUL_STEPS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= MUL_IDLE;
      cnt_q   <= '0;
    end else if (step_en) begin
      state_q <= mul_last ? MUL_IDLE : MUL_RUN;
      cnt_q   <= cnt_cur + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (step_en) begin
      acc_q    <= acc_cur + partial;         // upper product bits drop off
      mcand_q  <= mcand_cur << step_w;
      mplier_q <= mplier_cur >> step_w;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      done_q <= 1'b0;
    end else if (ctrl_i.flush.ex || !ctrl_i.stall.ex) begin
      done_q <= 1'b0;                        // ex takes a new entry
    end else if (step_en && mul_last) begin
      done_q <= 1'b1;
    end
  end

  always_comb begin
    case (ex_q.opcode)
      OP_ADD:  alu_res = ex_q.op_a + ex_q.op_b;
      OP_SUB:  alu_res = ex_q.op_a - ex_q.op_b;
      OP_XOR:  alu_res = ex_q.op_a ^ ex_q.op_b;
      OP_MUL:  alu_res = acc_q;
      OP_LI:   alu_res = data_t'(ex_q.imm);  // zero extended
      default: alu_res = '0;
    endcase
  end

  // skip stays requested until id gets flushed
  assign skip_now   = ex_q.valid && (ex_q.opcode == OP_SKIPZ) && (ex_q.op_a == '0);
  assign skip_req_o = skip_now || skip_pend_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      skip_pend_q <= 1'b0;
    end else begin
      skip_pend_q <= skip_req_o && !ctrl_i.flush.id;
    end
  end

  assign ex_wb_o   = '{valid: writes_rd && !mul_busy_o, rd: ex_q.rd, value: alu_res};
  assign ex_dest_o = '{valid: writes_rd, rd: ex_q.rd};

  a_step_cnt_range: assert property (@(posedge clk) disable iff (rst)
    cnt_q <= cnt_w'(`MP_MUL_STEPS));

  a_skip_drop: assert property (@(posedge clk) disable iff (rst)
    $fell(skip_req_o) |-> $past(ctrl_i.flush.id));

endmodule

// File: hw/writeback_stage.sv
`timescale 1ns/10ps

module writeback_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  mini_pipe_pkg::pipe_ctrl_t ctrl_i,
  input  mini_pipe_pkg::ex_wb_t     ex_wb_i,
  output logic                      res_valid_o,
  output mini_pipe_pkg::result_t    res_o,
  input  logic                      res_ready_i,
  output logic                      wb_hold_o,
  output mini_pipe_pkg::dest_t      wb_dest_o,
  output logic                      we_o,
  output mini_pipe_pkg::reg_idx_t   wa_o,
  output mini_pipe_pkg::data_t      wd_o
);
  import mini_pipe_pkg::*;

  ex_wb_t wb_q;

  // entry held while the consumer stalls
  always_ff @(posedge clk) begin
    if (rst || ctrl_i.flush.wb) begin
      wb_q.valid <= 1'b0;
    end else if (!ctrl_i.stall.wb) begin
      wb_q <= ex_wb_i;
    end
  end

  assign res_valid_o = wb_q.valid;
  assign res_o       = '{rd: wb_q.rd, value: wb_q.value};
  assign wb_hold_o   = res_valid_o && !res_ready_i;

  assign wb_dest_o = '{valid: wb_q.valid, rd: wb_q.rd};

  // regfile updated on the output handshake
  assign we_o = res_valid_o && res_ready_i;
  assign wa_o = wb_q.rd;
  assign wd_o = wb_q.value;

  a_res_stable: assert property (@(posedge clk) disable iff (rst)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o));

endmodule

// File: hw/hazard_control.sv
`timescale 1ns/10ps

module hazard_control (
  input  logic                      rst,
  input  logic                      wb_hold_i,     // result waiting at output
  input  logic                      mul_busy_i,    // multiplier still stepping
  input  logic                      skip_req_i,    // taken skipz pending
  input  logic                      id_valid_i,
  input  logic                      raw_hazard_i,  // id source not written yet
  output mini_pipe_pkg::pipe_ctrl_t ctrl_o
);
  import mini_pipe_pkg::*;

  // vector bits are fetch id ex wb from msb down
  localparam pipe_ctrl_t ctrl_reset   = '{stall: 4'b0000, flush: 4'b1111};
  localparam pipe_ctrl_t ctrl_wb_hold = '{stall: 4'b1111, flush: 4'b0000};
  localparam pipe_ctrl_t ctrl_mul     = '{stall: 4'b1110, flush: 4'b0000};
  localparam pipe_ctrl_t ctrl_skip    = '{stall: 4'b1000, flush: 4'b0100};  // kill id
  localparam pipe_ctrl_t ctrl_raw     = '{stall: 4'b1100, flush: 4'b0010};  // bubble into ex
  localparam pipe_ctrl_t ctrl_run     = '{stall: 4'b0000, flush: 4'b0000};

  // later stage wins
  always_comb begin
    if (rst) begin
      ctrl_o = ctrl_reset;
    end else if (wb_hold_i) begin
      ctrl_o = ctrl_wb_hold;
    end else if (mul_busy_i) begin
      ctrl_o = ctrl_mul;
    end else if (skip_req_i && id_valid_i) begin  // skip with empty id waits for next instr
      ctrl_o = ctrl_skip;
    end else if (raw_hazard_i) begin
      ctrl_o = ctrl_raw;
    end else begin
      ctrl_o = ctrl_run;
    end
  end

endmodule

// File: hw/mini_pipe_top.sv
`timescale 1ns/10ps

module mini_pipe_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   instr_valid_i,
  input  mini_pipe_pkg::instr_t  instr_i,
  output logic                   instr_ready_o,
  output logic                   res_valid_o,
  output mini_pipe_pkg::result_t res_o,
  input  logic                   res_ready_i
);
  import mini_pipe_pkg::*;

  pipe_ctrl_t ctrl;        // common stall/flush word
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  data_t      rd1;
  data_t      rd2;
  dest_t      ex_dest;
  dest_t      wb_dest;
  id_ex_t     id_ex;
  ex_wb_t     ex_wb;
  logic       raw_hazard;
  logic       id_valid;
  logic       mul_busy;
  logic       skip_req;
  logic       wb_hold;
  logic       we;          // regfile write port
  reg_idx_t   wa;
  data_t      wd;

  reg_file u_reg_file (
    .clk(clk), .rst(rst), .rs1_i(rs1), .rs2_i(rs2), .rd1_o(rd1), .rd2_o(rd2),
    .we_i(we), .wa_i(wa), .wd_i(wd)
  );

  decode_stage u_decode (
    .clk(clk), .rst(rst), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
    .instr_ready_o(instr_ready_o), .ctrl_i(ctrl), .rs1_o(rs1), .rs2_o(rs2),
    .rd1_i(rd1), .rd2_i(rd2), .ex_dest_i(ex_dest), .wb_dest_i(wb_dest),
    .raw_hazard_o(raw_hazard), .id_valid_o(id_valid), .id_ex_o(id_ex)
  );

  execute_stage u_execute (
    .clk(clk), .rst(rst), .ctrl_i(ctrl), .id_ex_i(id_ex), .ex_wb_o(ex_wb),
    .ex_dest_o(ex_dest), .mul_busy_o(mul_busy), .skip_req_o(skip_req)
  );

  writeback_stage u_writeback (
    .clk(clk), .rst(rst), .ctrl_i(ctrl), .ex_wb_i(ex_wb), .res_valid_o(res_valid_o),
    .res_o(res_o), .res_ready_i(res_ready_i), .wb_hold_o(wb_hold),
    .wb_dest_o(wb_dest), .we_o(we), .wa_o(wa), .wd_o(wd)
  );

  hazard_control u_hazard (
    .rst(rst), .wb_hold_i(wb_hold), .mul_busy_i(mul_busy), .skip_req_i(skip_req),
    .id_valid_i(id_valid), .raw_hazard_i(raw_hazard), .ctrl_o(ctrl)
  );

endmodule

// File: verification/mini_pipe_tb.sv
`timescale 1ns/10ps
`include "mini_pipe_config.svh"

module mini_pipe_tb;
  import mini_pipe_pkg::*;

  logic    clk;
  logic    rst;
  logic    instr_valid_i;
  instr_t  instr_i;
  logic    instr_ready_o;
  logic    res_valid_o;
  result_t res_o;
  logic    res_ready_i;

  instr_t      prog[$];      // program in issue order
  int          gaps[$];      // idle cycles before each instr
  string       tags[$];      // test name per instr
  reg_idx_t    exp_rd[$];    // expected results, program order
  data_t       exp_val[$];
  string       exp_tag[$];
  logic [31:0] seed = 32'ha823;
  int          cycles = 0;
  int          timeout_cycles = 0;
  logic        held = 1'b0;  // result waiting for ready
  result_t     held_res;

  mini_pipe_top UUT (
    .clk(clk), .rst(rst), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
    .instr_ready_o(instr_ready_o), .res_valid_o(res_valid_o), .res_o(res_o),
    .res_ready_i(res_ready_i)
  );

  always #10 clk = ~clk;

  function automatic logic [15:0] rand_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[31:16];  // low bits of an lcg repeat too soon
  endfunction

  function automatic instr_t enc_rrr(opcode_e op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {op, rd, rs1, rs2, 4'b0000};
  endfunction

  function automatic instr_t enc_li(reg_idx_t rd, logic [6:0] imm);
    return {OP_LI, rd, 3'b000, imm};
  endfunction

  function automatic void add_instr(instr_t ins, int gap, string tag);
    prog.push_back(ins);
    gaps.push_back(gap);
    tags.push_back(tag);
  endfunction

  function automatic void build_program();
    logic [15:0] r;
    // registers still zero from reset
    add_instr(enc_rrr(OP_ADD, 0, 1, 2), 0, "reset_zero");
    add_instr(enc_rrr(OP_SUB, 3, 4, 5), 0, "reset_zero");
    add_instr(enc_rrr(OP_XOR, 6, 7, 0), 0, "reset_zero");
    add_instr(enc_rrr(OP_MUL, 1, 2, 3), 0, "reset_zero");
    // independent alu ops, spaced out
    add_instr(enc_li(1, 7'd5), 4, "alu");
    add_instr(enc_li(2, 7'd100), 4, "alu");
    add_instr(enc_li(3, 7'd127), 4, "alu");
    add_instr(enc_rrr(OP_ADD, 4, 1, 2), 4, "alu");
    add_instr(enc_rrr(OP_SUB, 5, 1, 3), 4, "alu");  // wraps negative
    add_instr(enc_rrr(OP_XOR, 6, 2, 3), 4, "alu");
    // back to back dependencies
    add_instr(enc_rrr(OP_ADD, 1, 1, 2), 0, "raw_chain");
    add_instr(enc_rrr(OP_ADD, 1, 1, 1), 0, "raw_chain");
    add_instr(enc_rrr(OP_SUB, 3, 1, 2), 0, "raw_chain");
    add_instr(enc_rrr(OP_XOR, 3, 3, 1), 0, "raw_chain");
    add_instr(enc_li(5, 7'd123), 0, "mul");
    add_instr(enc_rrr(OP_MUL, 6, 5, 5), 0, "mul");
    add_instr(enc_rrr(OP_MUL, 6, 6, 5), 0, "mul");
    add_instr(enc_rrr(OP_ADD, 7, 6, 1), 0, "mul");
    add_instr(enc_rrr(OP_MUL, 7, 7, 6), 0, "mul");
    add_instr(enc_li(0, 7'd0), 0, "skipz");
    add_instr(enc_rrr(OP_SKIPZ, 0, 0, 0), 0, "skipz");  // taken
    add_instr(enc_li(1, 7'd77), 0, "skipz");             // discarded
    add_instr(enc_rrr(OP_SKIPZ, 0, 2, 0), 0, "skipz");  // r2 nonzero
    add_instr(enc_li(1, 7'd9), 0, "skipz");
    add_instr(enc_rrr(OP_SKIPZ, 0, 0, 0), 0, "skipz");
    add_instr(enc_li(4, 7'd1), 6, "skipz");              // arrives late, discarded
    add_instr(enc_rrr(OP_SKIPZ, 0, 0, 0), 0, "skipz");
    add_instr(enc_rrr(OP_SKIPZ, 0, 0, 0), 0, "skipz");  // skipped skipz
    add_instr(enc_rrr(OP_ADD, 4, 4, 1), 0, "skipz");
    for (int i = 0; i < 400; i++) begin
      r = rand_next() % 16;
      case (r)
        0, 1, 2:   add_instr(enc_rrr(OP_ADD, rand_next(), rand_next(), rand_next()), 0, "random");
        3, 4:      add_instr(enc_rrr(OP_SUB, rand_next(), rand_next(), rand_next()), 0, "random");
        5, 6:      add_instr(enc_rrr(OP_XOR, rand_next(), rand_next(), rand_next()), 0, "random");
        7, 8:      add_instr(enc_rrr(OP_MUL, rand_next(), rand_next(), rand_next()), 0, "random");
        12, 13:    add_instr(enc_rrr(OP_SKIPZ, 0, rand_next(), 0), 0, "random");
        default:   add_instr(enc_li(rand_next(), (rand_next() % 4 == 0) ? 7'd0 : rand_next()),
                             0, "random");  // zeros feed skipz
      endcase
      if (rand_next() % 8 == 0) gaps[gaps.size()-1] = rand_next() % 3 + 1;
    end
  endfunction

  // sequential model of the whole program
  function automatic void run_model();
    data_t    regs [`MP_NREGS];
    logic     skip_next;
    opcode_e  op;
    reg_idx_t rd;
    data_t    a;
    data_t    b;
    data_t    v;
    skip_next = 1'b0;
    for (int i = 0; i < `MP_NREGS; i++) regs[i] = '0;
    for (int i = 0; i < prog.size(); i++) begin
      if (skip_next) begin
        skip_next = 1'b0;
        continue;
      end
      op = opcode_e'(prog[i][15:13]);
      rd = prog[i][12:10];
      a  = regs[prog[i][9:7]];
      b  = regs[prog[i][6:4]];
      case (op)
        OP_ADD:  v = a + b;
        OP_SUB:  v = a - b;
        OP_XOR:  v = a ^ b;
        OP_MUL:  v = a * b;                // keeps low half
        OP_LI:   v = data_t'(prog[i][6:0]);
        default: v = '0;
      endcase
      if (op == OP_SKIPZ) begin
        skip_next = (a == '0);
      end else begin
        regs[rd] = v;
        exp_rd.push_back(rd);
        exp_val.push_back(v);
        exp_tag.push_back(tags[i]);
      end
    end
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_rd(input string test, input reg_idx_t exp, input reg_idx_t act);
    if (exp !== act) abort_run($sformatf("ERR %s rd expected %0d actual %0d", test, exp, act));
  endtask

  task automatic check_value(input string test, input data_t exp, input data_t act);
    if (exp !== act) abort_run($sformatf("ERR %s value expected %h actual %h", test, exp, act));
  endtask

  // called at a falling edge, returns at the falling edge after the handshake
  task automatic send_instr(input instr_t ins);
    logic taken;
    taken = 1'b0;
    instr_valid_i = 1'b1;
    instr_i = ins;
    while (!taken) begin
      #1;
      taken = instr_ready_o;  // holds until the rising edge
      @(negedge clk);
    end
    instr_valid_i = 1'b0;
  endtask

  initial begin
    res_ready_i = 1'b1;
    @(negedge rst);
    forever begin
      @(negedge clk);
      res_ready_i = (rand_next() % 4) != 0;  // ready 3 cycles in 4
    end
  end

  // output port sampled between edges
  always @(negedge clk) begin
    #2;
    if (!rst) begin
      if (held && !res_valid_o) abort_run("result withdrawn before it was taken");
      if (held) begin
        check_rd("hold_stable", held_res.rd, res_o.rd);
        check_value("hold_stable", held_res.value, res_o.value);
      end
      held = res_valid_o && !res_ready_i;
      held_res = res_o;
      if (res_valid_o && res_ready_i) begin
        if (exp_rd.size() == 0) abort_run("result appeared that the program does not produce");
        check_rd(exp_tag[0], exp_rd[0], res_o.rd);
        check_value(exp_tag[0], exp_val[0], res_o.value);
        void'(exp_rd.pop_front());
        void'(exp_val.pop_front());
        void'(exp_tag.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (timeout_cycles > 0 && cycles >= timeout_cycles) begin
      abort_run($sformatf("pipeline hung, %0d results still missing", exp_rd.size()));
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    instr_valid_i = 1'b0;
    instr_i = '0;
    build_program();
    run_model();
    timeout_cycles = prog.size() * (`MP_MUL_STEPS + 4) * 4;
    repeat (4) @(posedge clk);
    @(negedge clk);
    if (res_valid_o !== 1'b0) abort_run("res_valid_o not low after reset");
    if (instr_ready_o !== 1'b1) abort_run("instr_ready_o not high after reset");
    rst = 1'b0;
    for (int i = 0; i < prog.size(); i++) begin
      repeat (gaps[i]) @(negedge clk);
      send_instr(prog[i]);
    end
    while (exp_rd.size() > 0) @(negedge clk);
    repeat (20) @(negedge clk);  // nothing extra may follow
    $display("Test OK");
    $finish;
  end

endmodule

// File: mini_pipe_top.f
+incdir+hw
hw/mini_pipe_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/hazard_control.sv
hw/mini_pipe_top.sv
verification/mini_pipe_tb.sv
